/* Bender.yml */
package:
  name: cpu_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/instr_decode.sv
      - rtl/alu_execute.sv
      - rtl/result_writeback.sv
      - rtl/cpu_sequencer.sv
      - rtl/cpu_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tests/cpu_assertions.sv
      - tests/cpu_tb.sv

/* build.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/cpu_sequencer.sv
rtl/cpu_top.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

/* rtl/alu_execute.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module alu_execute
    import cpu_pkg::*;
(
    input  alu_op_t              alu_op,
    input  logic [`CPU_XLEN-1:0] operand_a,
    input  logic [`CPU_XLEN-1:0] operand_b,
    input  logic [15:0]          imm,
    input  logic                 flag_in,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 result_flag
);

    logic [`CPU_XLEN:0]   sum;
    logic [`CPU_XLEN:0]   diff;
    logic                 carry_in;
    logic [`CPU_XLEN-1:0] logic_res;

    // addc feeds the selected flag in as carry
    assign carry_in = (alu_op == ALU_ADDC) ? flag_in : 1'b0;

    assign sum = {1'b0, operand_a} + {1'b0, operand_b} + {{`CPU_XLEN{1'b0}}, carry_in};

    // top bit is the borrow
    assign diff = {1'b0, operand_a} - {1'b0, operand_b};

    always_comb
    begin
        case (alu_op)
            ALU_AND: logic_res = operand_a & operand_b;
            ALU_OR:  logic_res = operand_a | operand_b;
            default: logic_res = operand_a ^ operand_b;
        endcase
    end

    always_comb
    begin
        case (alu_op)
            ALU_ADD, ALU_ADDC:
            begin
                result = sum[`CPU_XLEN-1:0];
                result_flag = sum[`CPU_XLEN];
            end
            ALU_SUB:
            begin
                result = diff[`CPU_XLEN-1:0];
                result_flag = diff[`CPU_XLEN];
            end
            ALU_AND, ALU_OR, ALU_XOR:
            begin
                result = logic_res;
                result_flag = (logic_res == '0);
            end
            ALU_CMPLT:
            begin
                // only the flag is written back
                result = diff[`CPU_XLEN-1:0];
                result_flag = (operand_a < operand_b);
            end
            ALU_PASS_IMM_LOW:
            begin
                result = {{(`CPU_XLEN-16){1'b0}}, imm};
                result_flag = 1'b0;
            end
            ALU_PASS_IMM_HIGH:
            begin
                result = {imm, operand_a[15:0]};
                result_flag = 1'b0;
            end
            default:
            begin
                result = operand_b;
                result_flag = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register file sizes
`define CPU_XLEN 32
`define CPU_NREGS 8
`define CPU_SELW 3

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// 7-bit opcodes where any other value executes as a no-op
`define OP_ADD 7'h01
`define OP_SUB 7'h02
`define OP_AND 7'h03
`define OP_OR 7'h04
`define OP_XOR 7'h05
`define OP_ADDC 7'h06
`define OP_CMPLT 7'h07
`define OP_LDI 7'h08
`define OP_LOAD 7'h09
`define OP_STORE 7'h0a
`define OP_BRF 7'h0b
`define OP_HALT 7'h0c

`endif

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // register view for alu, load and store opcodes
    typedef struct packed {
        logic [12:0] pad;
        logic [2:0]  fsel;
        logic [2:0]  rd;
        logic [2:0]  rb;
        logic [2:0]  ra;
        logic [6:0]  opcode;
    } instr_reg_t;

    // immediate view for ldi and brf
    typedef struct packed {
        logic [15:0] imm;
        logic [1:0]  pad;
        logic        high;
        logic [2:0]  rd;
        logic [2:0]  ra;
        logic [6:0]  opcode;
    } instr_imm_t;

    // rd moves between the two views so the opcode picks one
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_ADDC,
        ALU_CMPLT,
        ALU_PASS_IMM_LOW,
        ALU_PASS_IMM_HIGH,
        ALU_PASS_B
    } alu_op_t;

endpackage

/* rtl/cpu_sequencer.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_sequencer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  logic [`CPU_XLEN-1:0] mem_rdata,
    input  logic [`CPU_XLEN-1:0] operand_a,
    input  logic [`CPU_XLEN-1:0] operand_b,
    input  logic                 flag_in,
    input  logic [15:0]          imm,
    input  logic                 is_load,
    input  logic                 is_store,
    input  logic                 is_branch,
    input  logic                 is_halt,
    output logic                 mem_req_valid,
    output logic [`CPU_XLEN-1:0] mem_addr,
    output logic                 mem_write,
    output logic [`CPU_XLEN-1:0] mem_wdata,
    output logic [`CPU_XLEN-1:0] instr_word,
    output logic                 commit,
    output logic                 load_commit,
    output logic [`CPU_XLEN-1:0] load_data,
    output logic                 halted
);

    // idle keeps the bus quiet for one cycle after reset
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_FETCH = 3'd1;
    localparam logic [2:0] ST_WAIT  = 3'd2;
    localparam logic [2:0] ST_EXEC  = 3'd3;
    localparam logic [2:0] ST_MEM   = 3'd4;
    localparam logic [2:0] ST_LWAIT = 3'd5;
    localparam logic [2:0] ST_HALT  = 3'd6;

    logic [2:0]           state;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pc_next;
    logic                 is_alu;

    assign pc_next = pc + 1'b1;
    assign is_alu = !(is_load || is_store || is_branch || is_halt);

    assign mem_req_valid = (state == ST_FETCH) || (state == ST_MEM);
    assign mem_addr = (state == ST_MEM) ? operand_a : pc;
    assign mem_write = (state == ST_MEM) && is_store;
    assign mem_wdata = operand_b;

    assign commit = (state == ST_EXEC) && is_alu;
    assign load_commit = (state == ST_LWAIT) && mem_rsp_valid;
    assign load_data = mem_rdata;
    assign halted = (state == ST_HALT);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            pc <= `CPU_RESET_PC;
            instr_word <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:  state <= ST_FETCH;
                ST_FETCH:
                begin
                    if (mem_req_ready)
                    begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT:
                begin
                    if (mem_rsp_valid)
                    begin
                        instr_word <= mem_rdata;
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC:
                begin
                    if (is_halt)
                    begin
                        state <= ST_HALT;
                    end
                    else if (is_load || is_store)
                    begin
                        state <= ST_MEM;
                    end
                    else
                    begin
                        // taken branch jumps to the zero-extended immediate
                        if (is_branch && flag_in)
                        begin
                            pc <= {{(`CPU_XLEN-16){1'b0}}, imm};
                        end
                        else
                        begin
                            pc <= pc_next;
                        end
                        state <= ST_FETCH;
                    end
                end
                ST_MEM:
                begin
                    if (mem_req_ready)
                    begin
                        if (is_load)
                        begin
                            state <= ST_LWAIT;
                        end
                        else
                        begin
                            pc <= pc_next;
                            state <= ST_FETCH;
                        end
                    end
                end
                ST_LWAIT:
                begin
                    if (mem_rsp_valid)
                    begin
                        pc <= pc_next;
                        state <= ST_FETCH;
                    end
                end
                ST_HALT:  state <= ST_HALT;
                default:  state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    output logic                 mem_req_valid,
    output logic                 mem_write,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    output logic [`CPU_XLEN-1:0] mem_addr,
    output logic [`CPU_XLEN-1:0] mem_wdata,
    input  logic [`CPU_XLEN-1:0] mem_rdata,
    output logic                 halted
);

    logic [`CPU_XLEN-1:0] instr_word;
    logic [`CPU_SELW-1:0] ra_sel;
    logic [`CPU_SELW-1:0] rb_sel;
    logic [`CPU_SELW-1:0] rd_sel;
    logic [`CPU_SELW-1:0] fsel;
    alu_op_t              alu_op;
    logic [15:0]          imm;
    logic                 wr_reg;
    logic                 wr_flag;
    logic                 is_load;
    logic                 is_store;
    logic                 is_branch;
    logic                 is_halt;
    logic [`CPU_XLEN-1:0] operand_a;
    logic [`CPU_XLEN-1:0] operand_b;
    logic                 flag_in;
    logic [`CPU_XLEN-1:0] result;
    logic                 result_flag;
    logic                 commit;
    logic                 load_commit;
    logic [`CPU_XLEN-1:0] load_data;

    cpu_sequencer u_sequencer (
        .clock         (clock),
        .reset         (reset),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .flag_in       (flag_in),
        .imm           (imm),
        .is_load       (is_load),
        .is_store      (is_store),
        .is_branch     (is_branch),
        .is_halt       (is_halt),
        .mem_req_valid (mem_req_valid),
        .mem_addr      (mem_addr),
        .mem_write     (mem_write),
        .mem_wdata     (mem_wdata),
        .instr_word    (instr_word),
        .commit        (commit),
        .load_commit   (load_commit),
        .load_data     (load_data),
        .halted        (halted)
    );

    instr_decode u_decode (
        .instr_word (instr_word),
        .ra_sel     (ra_sel),
        .rb_sel     (rb_sel),
        .rd_sel     (rd_sel),
        .fsel       (fsel),
        .alu_op     (alu_op),
        .imm        (imm),
        .wr_reg     (wr_reg),
        .wr_flag    (wr_flag),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_branch  (is_branch),
        .is_halt    (is_halt)
    );

    alu_execute u_execute (
        .alu_op      (alu_op),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .imm         (imm),
        .flag_in     (flag_in),
        .result      (result),
        .result_flag (result_flag)
    );

    result_writeback u_writeback (
        .clock       (clock),
        .reset       (reset),
        .commit      (commit),
        .load_commit (load_commit),
        .wr_reg      (wr_reg),
        .wr_flag     (wr_flag),
        .ra_sel      (ra_sel),
        .rb_sel      (rb_sel),
        .rd_sel      (rd_sel),
        .fsel        (fsel),
        .result      (result),
        .load_data   (load_data),
        .result_flag (result_flag),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .flag_in     (flag_in)
    );

endmodule

/* rtl/instr_decode.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module instr_decode
    import cpu_pkg::*;
(
    input  logic [31:0]          instr_word,
    output logic [`CPU_SELW-1:0] ra_sel,
    output logic [`CPU_SELW-1:0] rb_sel,
    output logic [`CPU_SELW-1:0] rd_sel,
    output logic [`CPU_SELW-1:0] fsel,
    output alu_op_t              alu_op,
    output logic [15:0]          imm,
    output logic                 wr_reg,
    output logic                 wr_flag,
    output logic                 is_load,
    output logic                 is_store,
    output logic                 is_branch,
    output logic                 is_halt
);

    instr_t instr;

    assign instr = instr_word;
    assign imm = instr.i.imm;

    always_comb
    begin
        // register view by default
        ra_sel = instr.r.ra;
        rb_sel = instr.r.rb;
        rd_sel = instr.r.rd;
        fsel = instr.r.fsel;
        alu_op = ALU_PASS_B;
        wr_reg = 1'b0;
        wr_flag = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        is_halt = 1'b0;

        case (instr.r.opcode)
            `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_ADDC:
            begin
                wr_reg = 1'b1;
                wr_flag = 1'b1;
                case (instr.r.opcode)
                    `OP_ADD:  alu_op = ALU_ADD;
                    `OP_SUB:  alu_op = ALU_SUB;
                    `OP_AND:  alu_op = ALU_AND;
                    `OP_OR:   alu_op = ALU_OR;
                    `OP_XOR:  alu_op = ALU_XOR;
                    default:  alu_op = ALU_ADDC;
                endcase
            end
            `OP_CMPLT:
            begin
                alu_op = ALU_CMPLT;
                wr_flag = 1'b1;
            end
            `OP_LDI:
            begin
                // ra must name rd so the high half keeps the low half
                ra_sel = instr.i.ra;
                rd_sel = instr.i.rd;
                alu_op = instr.i.high ? ALU_PASS_IMM_HIGH : ALU_PASS_IMM_LOW;
                wr_reg = 1'b1;
            end
            `OP_LOAD:  is_load = 1'b1;
            `OP_STORE: is_store = 1'b1;
            `OP_BRF:
            begin
                // flag select sits in the ra slot of the immediate view
                fsel = instr.i.ra;
                rd_sel = instr.i.rd;
                is_branch = 1'b1;
            end
            `OP_HALT:  is_halt = 1'b1;
            default:   ;
        endcase
    end

endmodule

/* rtl/result_writeback.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module result_writeback (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 commit,
    input  logic                 load_commit,
    input  logic                 wr_reg,
    input  logic                 wr_flag,
    input  logic [`CPU_SELW-1:0] ra_sel,
    input  logic [`CPU_SELW-1:0] rb_sel,
    input  logic [`CPU_SELW-1:0] rd_sel,
    input  logic [`CPU_SELW-1:0] fsel,
    input  logic [`CPU_XLEN-1:0] result,
    input  logic [`CPU_XLEN-1:0] load_data,
    input  logic                 result_flag,
    output logic [`CPU_XLEN-1:0] operand_a,
    output logic [`CPU_XLEN-1:0] operand_b,
    output logic                 flag_in
);

    logic [`CPU_XLEN-1:0]  regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0] flags;

    // asynchronous read ports
    assign operand_a = regs[ra_sel];
    assign operand_b = regs[rb_sel];
    assign flag_in = flags[fsel];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else
        begin
            if (commit && wr_reg)
            begin
                regs[rd_sel] <= result;
            end
            // load completes in a cycle without commit
            if (load_commit)
            begin
                regs[rd_sel] <= load_data;
            end
            // flag rd travels with register rd
            if (commit && wr_flag)
            begin
                flags[rd_sel] <= result_flag;
            end
        end
    end

endmodule

/* tests/cpu_assertions.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_assertions (
    input logic                 clock,
    input logic                 reset,
    input logic                 mem_req_valid,
    input logic                 mem_req_ready,
    input logic                 mem_write,
    input logic [`CPU_XLEN-1:0] mem_addr,
    input logic [`CPU_XLEN-1:0] mem_wdata,
    input logic                 mem_rsp_valid,
    input logic                 halted
);

    int   failures = 0;
    logic read_pending;

    // at most one read outstanding until its response
    always_ff @(posedge clock)
    begin
        if (reset)
            read_pending <= 1'b0;
        else if (mem_rsp_valid)
            read_pending <= 1'b0;
        else if (mem_req_valid && mem_req_ready && !mem_write)
            read_pending <= 1'b1;
    end

    request_stable: assert property (@(posedge clock) disable iff (reset)
        (mem_req_valid && !mem_req_ready) |=>
            (mem_req_valid && $stable(mem_addr) && $stable(mem_write) && $stable(mem_wdata)))
    else
    begin
        failures++;
        $error("request fields changed under back-pressure");
    end

    quiet_when_halted: assert property (@(posedge clock) disable iff (reset)
        halted |-> !mem_req_valid)
    else
    begin
        failures++;
        $error("request made while halted");
    end

    response_expected: assert property (@(posedge clock) disable iff (reset)
        mem_rsp_valid |-> read_pending)
    else
    begin
        failures++;
        $error("read response without a pending read");
    end

endmodule

bind cpu_top cpu_assertions u_assertions (.*);

/* tests/cpu_tb.sv */
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_tb;

    localparam int MEM_WORDS = 256;
    localparam int PROG_LEN = 41;
    localparam int NUM_STORES = 9;
    localparam int HALT_TIMEOUT = 4000;
    localparam logic [31:0] SEED = 32'd9;
    localparam logic [31:0] DATA_BASE = 32'h0000_0080;
    localparam logic [31:0] VAL_A = 32'h1234_5678;
    localparam logic [31:0] VAL_B = 32'h0f0f_f0f0;
    localparam logic [31:0] ALL_ONES = 32'hffff_ffff;
    localparam logic [31:0] DATA_WORD = 32'hcafe_f00d;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic        mem_req_ready = 1'b0;
    logic        mem_rsp_valid = 1'b0;
    logic [31:0] mem_rdata = '0;
    logic        mem_req_valid;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        halted;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] program_rom [PROG_LEN];
    logic [31:0] exp_addr [NUM_STORES];
    logic [31:0] exp_data [NUM_STORES];
    logic [31:0] rng_state = SEED;
    logic        stall_enable = 1'b0;
    logic        rsp_pending = 1'b0;
    logic [1:0]  rsp_delay = '0;
    logic [7:0]  rsp_addr = '0;
    logic        in_reset = 1'b0;
    logic        first_req_open = 1'b0;
    int          store_idx = 0;
    int          mismatch_count = 0;
    int          protocol_count = 0;
    int          other_count = 0;

    always #2 clock = ~clock;

    cpu_top u_dut (
        .clock         (clock),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_write     (mem_write),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .halted        (halted)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // register view with opcode ra rb rd fsel from bit 0 upward
    function automatic logic [31:0] reg_form(input logic [6:0] op, input logic [2:0] ra,
                                             input logic [2:0] rb, input logic [2:0] rd,
                                             input logic [2:0] fsel);
        return {13'b0, fsel, rd, rb, ra, op};
    endfunction

    // immediate view where brf puts its flag select in the ra slot
    function automatic logic [31:0] imm_form(input logic [6:0] op, input logic [2:0] ra,
                                             input logic [2:0] rd, input logic high,
                                             input logic [15:0] imm);
        return {imm, 2'b0, high, rd, ra, op};
    endfunction

    task automatic build_tables();
        program_rom[0] = imm_form(`OP_LDI, 3'd1, 3'd1, 1'b0, VAL_A[15:0]);
        program_rom[1] = imm_form(`OP_LDI, 3'd1, 3'd1, 1'b1, VAL_A[31:16]);
        program_rom[2] = imm_form(`OP_LDI, 3'd2, 3'd2, 1'b0, VAL_B[15:0]);
        program_rom[3] = imm_form(`OP_LDI, 3'd2, 3'd2, 1'b1, VAL_B[31:16]);
        program_rom[4] = reg_form(`OP_ADD, 3'd1, 3'd2, 3'd3, 3'd0);
        program_rom[5] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0040);
        program_rom[6] = reg_form(`OP_STORE, 3'd7, 3'd3, 3'd0, 3'd0);
        program_rom[7] = reg_form(`OP_SUB, 3'd1, 3'd2, 3'd3, 3'd0);
        program_rom[8] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0041);
        program_rom[9] = reg_form(`OP_STORE, 3'd7, 3'd3, 3'd0, 3'd0);
        program_rom[10] = reg_form(`OP_AND, 3'd1, 3'd2, 3'd3, 3'd0);
        program_rom[11] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0042);
        program_rom[12] = reg_form(`OP_STORE, 3'd7, 3'd3, 3'd0, 3'd0);
        program_rom[13] = reg_form(`OP_OR, 3'd1, 3'd2, 3'd3, 3'd0);
        program_rom[14] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0043);
        program_rom[15] = reg_form(`OP_STORE, 3'd7, 3'd3, 3'd0, 3'd0);
        program_rom[16] = reg_form(`OP_XOR, 3'd1, 3'd2, 3'd3, 3'd0);
        program_rom[17] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0044);
        program_rom[18] = reg_form(`OP_STORE, 3'd7, 3'd3, 3'd0, 3'd0);
        // r4 all ones plus r5 = 2 overflows into flag 6
        program_rom[19] = imm_form(`OP_LDI, 3'd4, 3'd4, 1'b0, ALL_ONES[15:0]);
        program_rom[20] = imm_form(`OP_LDI, 3'd4, 3'd4, 1'b1, ALL_ONES[31:16]);
        program_rom[21] = imm_form(`OP_LDI, 3'd5, 3'd5, 1'b0, 16'h0002);
        program_rom[22] = reg_form(`OP_ADD, 3'd4, 3'd5, 3'd6, 3'd0);
        program_rom[23] = reg_form(`OP_ADDC, 3'd1, 3'd2, 3'd3, 3'd6);
        program_rom[24] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0045);
        program_rom[25] = reg_form(`OP_STORE, 3'd7, 3'd6, 3'd0, 3'd0);
        program_rom[26] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0046);
        program_rom[27] = reg_form(`OP_STORE, 3'd7, 3'd3, 3'd0, 3'd0);
        // taken branch skips the store at 31
        program_rom[28] = reg_form(`OP_CMPLT, 3'd5, 3'd4, 3'd0, 3'd0);
        program_rom[29] = imm_form(`OP_BRF, 3'd0, 3'd0, 1'b0, 16'd32);
        program_rom[30] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h004f);
        program_rom[31] = reg_form(`OP_STORE, 3'd7, 3'd1, 3'd0, 3'd0);
        // not taken since a jump to halt would drop the next store
        program_rom[32] = reg_form(`OP_CMPLT, 3'd4, 3'd5, 3'd1, 3'd0);
        program_rom[33] = imm_form(`OP_BRF, 3'd1, 3'd0, 1'b0, 16'd40);
        program_rom[34] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0047);
        program_rom[35] = reg_form(`OP_STORE, 3'd7, 3'd2, 3'd0, 3'd0);
        program_rom[36] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, DATA_BASE[15:0]);
        program_rom[37] = reg_form(`OP_LOAD, 3'd7, 3'd0, 3'd3, 3'd0);
        program_rom[38] = imm_form(`OP_LDI, 3'd7, 3'd7, 1'b0, 16'h0048);
        program_rom[39] = reg_form(`OP_STORE, 3'd7, 3'd3, 3'd0, 3'd0);
        program_rom[40] = reg_form(`OP_HALT, 3'd0, 3'd0, 3'd0, 3'd0);

        exp_data[0] = VAL_A + VAL_B;
        exp_data[1] = VAL_A - VAL_B;
        exp_data[2] = VAL_A & VAL_B;
        exp_data[3] = VAL_A | VAL_B;
        exp_data[4] = VAL_A ^ VAL_B;
        // all ones plus two wraps to one and sets the carry
        exp_data[5] = 32'h0000_0001;
        exp_data[6] = VAL_A + VAL_B + 32'd1;
        exp_data[7] = VAL_B;
        exp_data[8] = DATA_WORD;
        for (int i = 0; i < NUM_STORES; i++)
        begin
            exp_addr[i] = 32'h40 + i;
        end
    endtask

    task automatic load_memory();
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            mem[a] <= 32'h5eed_0000 + a;
        end
        for (int i = 0; i < PROG_LEN; i++)
        begin
            mem[i] <= program_rom[i];
        end
        mem[DATA_BASE] <= DATA_WORD;
    endtask

    task automatic check_store(input int idx, input logic [31:0] addr, input logic [31:0] data);
        assert (idx < NUM_STORES)
        else
        begin
            other_count++;
            $display("unexpected extra store of %h to address %h", data, addr);
        end
        if (idx < NUM_STORES)
        begin
            assert (addr == exp_addr[idx] && data == exp_data[idx])
            else
            begin
                mismatch_count++;
                $display("Mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
                         $time, idx, data, addr, exp_data[idx], exp_addr[idx]);
            end
        end
    endtask

    // memory model with stalls and response delays from the lcg
    always @(posedge clock)
    begin
        rng_state = lcg_next(rng_state);
        if (reset)
        begin
            if (in_reset)
            begin
                assert (!mem_req_valid)
                else
                begin
                    protocol_count++;
                    $display("memory request made during reset at %0t", $time);
                end
            end
            in_reset <= 1'b1;
            first_req_open <= 1'b1;
            store_idx <= 0;
            rsp_pending <= 1'b0;
            mem_rsp_valid <= 1'b0;
            mem_req_ready <= 1'b0;
        end
        else
        begin
            in_reset <= 1'b0;
            mem_rsp_valid <= 1'b0;
            if (rsp_pending)
            begin
                if (rsp_delay == 2'd0)
                begin
                    mem_rsp_valid <= 1'b1;
                    mem_rdata <= mem[rsp_addr];
                    rsp_pending <= 1'b0;
                end
                else
                begin
                    rsp_delay <= rsp_delay - 2'd1;
                end
            end
            if (mem_req_valid && first_req_open)
            begin
                assert (!mem_write && mem_addr == 32'h0)
                else
                begin
                    protocol_count++;
                    $display("first request after reset is not a read of address 0");
                end
                first_req_open <= 1'b0;
            end
            assert (!(halted && mem_req_valid))
            else
            begin
                protocol_count++;
                $display("memory request made while halted at %0t", $time);
            end
            if (mem_req_valid && mem_req_ready)
            begin
                if (mem_write)
                begin
                    check_store(store_idx, mem_addr, mem_wdata);
                    store_idx <= store_idx + 1;
                    mem[mem_addr[7:0]] <= mem_wdata;
                end
                else
                begin
                    rsp_pending <= 1'b1;
                    rsp_addr <= mem_addr[7:0];
                    rsp_delay <= stall_enable ? rng_state[21:20] : 2'd0;
                end
            end
            mem_req_ready <= stall_enable ? (rng_state[17:16] != 2'b00) : 1'b1;
        end
    end

    task automatic run_program(input logic stalls, output logic ok);
        int cycles;
        @(posedge clock);
        reset <= 1'b1;
        stall_enable <= stalls;
        @(negedge clock);
        load_memory();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT)
        begin
            @(negedge clock);
            cycles++;
        end
        ok = halted;
        if (!ok)
        begin
            other_count++;
            $display("timeout, halted did not rise within %0d cycles", HALT_TIMEOUT);
        end
        else
        begin
            // halted holds and the bus stays quiet
            repeat (8)
            begin
                @(negedge clock);
                assert (halted && !mem_req_valid)
                else
                begin
                    protocol_count++;
                    $display("halted dropped or a request followed halt at %0t", $time);
                end
            end
            assert (store_idx == NUM_STORES)
            else
            begin
                other_count++;
                $display("only %0d of %0d expected stores were seen", store_idx, NUM_STORES);
            end
        end
    endtask

    task automatic report_result();
        int total;
        total = mismatch_count + protocol_count + other_count + u_dut.u_assertions.failures;
        $display("errors: %0d mismatch, %0d protocol, %0d other, %0d assertion",
                 mismatch_count, protocol_count, other_count, u_dut.u_assertions.failures);
        if (total == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    // first pass without stalls and second with random stalls
    initial
    begin
        logic ok;
        build_tables();
        for (int pass = 0; pass < 2; pass++)
        begin
            run_program(pass == 1, ok);
            if (!ok)
                break;
        end
        report_result();
    end

endmodule
